// ==== list.f ====
+incdir+verif
src/breakout_pkg.sv
src/ball_dir_fsm.sv
src/ball_motion.sv
src/paddle_ctrl.sv
src/brick_wall.sv
src/pixel_render.sv
src/breakout_top.sv
verif/breakout_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= breakout_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+') verif/breakout_model.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "*** TEST FAILED ***" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF "*** TEST PASSED ***" $(LOG); then \
		echo "simulation gave no result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/breakout_model.svh ====
`ifndef BREAKOUT_MODEL_SVH
`define BREAKOUT_MODEL_SVH

//////////////////////////////////////////////////
// reference state of the game
//////////////////////////////////////////////////

// headings, own encoding
localparam int head_idle = 0;
localparam int head_ul   = 1;
localparam int head_ur   = 2;
localparam int head_dr   = 3;
localparam int head_dl   = 4;

logic [95:0] exp_present;
logic [1:0]  exp_sw;
int          exp_left;
int          exp_bx;
int          exp_by;
int          exp_dir;

function automatic int paddle_width_for(input logic [1:0] s);
    case (s)
        2'b00: return 600;
        2'b01: return 40;
        default: return 30;
    endcase
endfunction

task automatic reset_model(input logic [1:0] s);
    exp_present = '1;
    exp_sw = s;
    exp_left = 320 - paddle_width_for(s) / 2;
    exp_bx = 316;
    exp_by = 445;
    exp_dir = head_idle;
endtask

// vertical reflection first, then horizontal, then paddle
function automatic int next_heading(input int d, input bit vert, input bit horiz,
                                    input bit wl, input bit wr, input bit wt, input bit pd);
    case (d)
        head_ul: begin
            if (vert || wt) return head_dl;
            else if (horiz || wl) return head_ur;
            else if (pd) return head_dr;
        end
        head_ur: begin
            if (vert || wt) return head_dr;
            else if (horiz || wr) return head_ul;
            else if (pd) return head_dl;
        end
        head_dr: begin
            if (vert || pd) return head_ur;
            else if (horiz || wr) return head_dl;
        end
        head_dl: begin
            if (vert || pd) return head_ul;
            else if (horiz || wl) return head_dr;
        end
        default: return d;
    endcase
    return d;
endfunction

// one frame update: step, flags, bricks, paddle, heading
task automatic step_frame(input logic [1:0] b, input logic [1:0] s, input bit st);
    int dx;
    int dy;
    int nx;
    int ny;
    int w;
    logic [9:0] tx;
    logic [9:0] ty;
    bit vert;
    bit horiz;
    bit pd;
    exp_sw = s;
    w = paddle_width_for(s);
    dx = (exp_dir == head_ur || exp_dir == head_dr) ? 1 : 0;
    dx = (exp_dir == head_ul || exp_dir == head_dl) ? -1 : dx;
    dy = (exp_dir == head_dr || exp_dir == head_dl) ? 1 : 0;
    dy = (exp_dir == head_ul || exp_dir == head_ur) ? -1 : dy;
    // coordinates wrap at 10 bits
    tx = 10'(exp_bx + dx);
    ty = 10'(exp_by + dy);
    nx = int'(tx);
    ny = int'(ty);
    vert = 1'b0;
    horiz = 1'b0;
    // paddle contact uses the edge before this frame's move
    pd = (ny >= 453) && (ny <= 457) && (nx >= exp_left) && (nx <= exp_left + w - 1);
    for (int r = 0; r < 6; r++) begin
        for (int c = 0; c < 16; c++) begin
            if (exp_present[r * 16 + c] && nx + 4 > c * 40 && nx < c * 40 + 40 &&
                ny + 4 > r * 30 && ny < r * 30 + 30) begin
                exp_present[r * 16 + c] = 1'b0;
                if (exp_by + 8 <= r * 30 || exp_by >= r * 30 + 30) vert = 1'b1;
                else if (exp_bx + 8 <= c * 40 || exp_bx >= c * 40 + 40) horiz = 1'b1;
            end
        end
    end
    if (b[0] && exp_left + w - 1 <= 638) exp_left = exp_left + 2;
    else if (b[1] && exp_left >= 2) exp_left = exp_left - 2;
    if (exp_dir == head_idle) begin
        if (st) exp_dir = head_ul;
    end else begin
        exp_dir = next_heading(exp_dir, vert, horiz, nx == 0, nx >= 632, ny == 0, pd);
    end
    exp_bx = nx;
    exp_by = ny;
endtask

// expected {graph_on, graph_rgb} at one pixel
function automatic logic [3:0] expected_pixel(input int px, input int py);
    int idx;
    logic [9:0] ox;
    logic [9:0] oy;
    logic [7:0] row;
    idx = (py / 30) * 16 + px / 40;
    if (py < 180 && px % 40 != 0 && py % 30 != 0 && exp_present[idx]) begin
        case (idx % 3)
            0: return 4'b1001;
            1: return 4'b1100;
            default: return 4'b1010;
        endcase
    end
    if (py >= 453 && py <= 457 && px >= exp_left &&
        px <= exp_left + paddle_width_for(exp_sw) - 1) return 4'b1110;
    ox = 10'(px - exp_bx);
    oy = 10'(py - exp_by);
    if (oy == 10'd0 || oy == 10'd7) row = 8'h3C;
    else if (oy == 10'd1 || oy == 10'd6) row = 8'h7E;
    else row = 8'hFF;
    if (ox < 10'd8 && oy < 10'd8 && row[ox[2:0]]) return 4'b1111;
    return 4'b0000;
endfunction

`endif

// ==== verif/breakout_tb.sv ====
`timescale 1ns/10ps

module breakout_tb;

    logic       clk;
    logic       reset;
    logic [1:0] btn;
    logic [1:0] sw;
    logic       start;
    logic [9:0] pix_x;
    logic [9:0] pix_y;
    logic       graph_on;
    logic [2:0] graph_rgb;

    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;

    // run length in frames and single-cycle pixel probes
    localparam int total_frames = 100 + 20 + 31 + 3000;
    localparam int total_probes = 268 + 400 + 20 * 64 + 30 * 64 + 60 * 128;
    localparam int watchdog_ns = (8 + total_frames * 4 + total_probes) * 8 * 2 + 1000;

    `include "breakout_model.svh"

    breakout_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .btn       (btn),
        .sw        (sw),
        .start     (start),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .graph_on  (graph_on),
        .graph_rgb (graph_rgb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus and probing
    //////////////////////////////////////////////////

    // one tick cycle and three quiet cycles
    task automatic run_frame(input logic [1:0] b, input logic [1:0] s, input bit st);
        @(posedge clk);
        #1;
        btn = b;
        sw = s;
        start = st;
        pix_x = 10'd0;
        pix_y = 10'd481;
        @(posedge clk);
        #1;
        pix_y = 10'd0;
        step_frame(b, s, st);
        repeat (2) @(posedge clk);
    endtask

    task automatic check_pixel(input string name, input int px, input int py);
        logic [3:0] exp_val;
        logic [3:0] act_val;
        @(posedge clk);
        #1;
        pix_x = 10'(px);
        pix_y = 10'(py);
        // colour path is combinational from the pixel position
        #4;
        exp_val = expected_pixel(px, py);
        act_val = {graph_on, graph_rgb};
        test_checks++;
        assert (act_val === exp_val) else begin
            $display("FAIL %s pixel (%0d,%0d) expected %h actual %h",
                     name, px, py, exp_val, act_val);
            test_errors++;
        end
    endtask

    // whole 8x8 box with the off-screen part skipped
    task automatic check_ball_box(input string name);
        int px;
        int py;
        for (int oy = 0; oy < 8; oy++) begin
            for (int ox = 0; ox < 8; ox++) begin
                px = (exp_bx + ox) % 1024;
                py = (exp_by + oy) % 1024;
                if (px < 640 && py < 480) check_pixel(name, px, py);
            end
        end
    endtask

    task automatic check_paddle_edges(input string name);
        int right;
        right = exp_left + paddle_width_for(exp_sw) - 1;
        if (exp_left > 0) check_pixel(name, exp_left - 1, 455);
        check_pixel(name, exp_left, 455);
        if (right < 640) check_pixel(name, right, 455);
        if (right + 1 < 640) check_pixel(name, right + 1, 455);
    endtask

    task automatic check_random_pixels(input string name, input int count);
        for (int i = 0; i < count; i++) begin
            check_pixel(name, int'($urandom_range(639, 0)), int'($urandom_range(479, 0)));
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [1:0] b;
        logic [1:0] s;
        void'($urandom(32'h4eb3b8bf));
        test_checks = 0;
        test_errors = 0;
        total_checks = 0;
        total_errors = 0;
        reset = 1'b0;
        btn = 2'b00;
        sw = 2'($urandom_range(3, 0));
        start = 1'b0;
        pix_x = 10'd0;
        pix_y = 10'd0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b1;
        reset_model(sw);

        // picture straight after reset
        check_random_pixels("reset_picture", 200);
        check_ball_box("reset_picture");
        check_paddle_edges("reset_picture");
        report_test("reset_picture");

        // each width in turn with the bias flipping per segment
        for (int i = 0; i < 100; i++) begin
            s = 2'(i / 25);
            if ((i / 25) % 2 == 0) b = {1'b0, $urandom_range(3, 0) != 0};
            else b = {$urandom_range(3, 0) != 0, 1'b0};
            run_frame(b, s, 1'b0);
            check_paddle_edges("paddle_motion");
        end
        report_test("paddle_motion");

        // ball stays put without start
        for (int i = 0; i < 20; i++) begin
            run_frame(2'($urandom_range(3, 0)), sw, 1'b0);
            check_ball_box("idle_hold");
        end
        report_test("idle_hold");

        // first frame only arms the heading
        run_frame(2'b00, sw, 1'b1);
        for (int i = 0; i < 30; i++) begin
            run_frame(2'($urandom_range(3, 0)), sw, 1'b1);
            check_ball_box("diagonal_motion");
        end
        report_test("diagonal_motion");

        s = sw;
        for (int i = 0; i < 3000; i++) begin
            if (i % 200 == 0) s = 2'($urandom_range(3, 0));
            run_frame(2'($urandom_range(3, 0)), s, 1'b1);
            if ((i + 1) % 50 == 0) begin
                check_random_pixels("full_play", 64);
                check_ball_box("full_play");
            end
        end
        report_test("full_play");

        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== src/breakout_top.sv ====
`timescale 1ns/10ps

module breakout_top #(
    parameter int BALL_SIZE = breakout_pkg::ball_size,
    parameter int BRICK_W   = breakout_pkg::brick_w,
    parameter int BRICK_H   = breakout_pkg::brick_h
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [1:0]           btn,
    input  logic [1:0]           sw,
    input  logic                 start,
    input  breakout_pkg::coord_t pix_x,
    input  breakout_pkg::coord_t pix_y,
    output logic                 graph_on,
    output breakout_pkg::rgb_t   graph_rgb
);
    import breakout_pkg::*;

    logic      frame_tick;
    logic      tick_q;
    dir_t      dir;
    ball_pos_t pos;
    ball_pos_t pos_next;
    coord_t    paddle_left;
    coord_t    paddle_width;
    hit_t      hit_wall_paddle;
    hit_t      hit_brick;
    hit_t      hit;
    logic      brick_pix;
    rgb_t      brick_rgb;

    // one update slot per frame, below the visible area
    assign frame_tick = (pix_y == coord_t'(frame_tick_y)) && (pix_x == '0);

    // flags land one cycle after the tick
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tick_q <= 1'b0;
        end else begin
            tick_q <= frame_tick;
        end
    end

    always_comb begin
        hit = hit_wall_paddle | hit_brick;
        hit.valid = tick_q;
    end

    //////////////////////////////////////////////////
    // datapath and control
    //////////////////////////////////////////////////

    ball_dir_fsm i_dir_fsm (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .hit   (hit),
        .dir   (dir)
    );

    ball_motion #(
        .BALL_SIZE (BALL_SIZE)
    ) i_ball_motion (
        .clk             (clk),
        .reset           (reset),
        .frame_tick      (frame_tick),
        .dir             (dir),
        .paddle_left     (paddle_left),
        .paddle_width    (paddle_width),
        .pos             (pos),
        .pos_next        (pos_next),
        .hit_wall_paddle (hit_wall_paddle)
    );

    paddle_ctrl i_paddle_ctrl (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .btn        (btn),
        .sw         (sw),
        .left       (paddle_left),
        .width      (paddle_width)
    );

    brick_wall #(
        .BALL_SIZE (BALL_SIZE),
        .BRICK_W   (BRICK_W),
        .BRICK_H   (BRICK_H)
    ) i_brick_wall (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .pos        (pos),
        .pos_next   (pos_next),
        .pix_x      (pix_x),
        .pix_y      (pix_y),
        .hit_brick  (hit_brick),
        .brick_pix  (brick_pix),
        .brick_rgb  (brick_rgb)
    );

    pixel_render i_pixel_render (
        .pix_x        (pix_x),
        .pix_y        (pix_y),
        .pos          (pos),
        .paddle_left  (paddle_left),
        .paddle_width (paddle_width),
        .brick_pix    (brick_pix),
        .brick_rgb    (brick_rgb),
        .graph_on     (graph_on),
        .graph_rgb    (graph_rgb)
    );

endmodule

// ==== src/pixel_render.sv ====
`timescale 1ns/10ps

module pixel_render (
    input  breakout_pkg::coord_t    pix_x,
    input  breakout_pkg::coord_t    pix_y,
    input  breakout_pkg::ball_pos_t pos,
    input  breakout_pkg::coord_t    paddle_left,
    input  breakout_pkg::coord_t    paddle_width,
    input  logic                    brick_pix,
    input  breakout_pkg::rgb_t      brick_rgb,
    output logic                    graph_on,
    output breakout_pkg::rgb_t      graph_rgb
);
    import breakout_pkg::*;

    coord_t     off_x;
    coord_t     off_y;
    logic [7:0] ball_row;
    logic       square_on;
    logic       ball_on;
    logic       paddle_on;

    // offset of the pixel inside the ball box
    assign off_x = pix_x - pos.x;
    assign off_y = pix_y - pos.y;

    // round ball mask, one byte per row
    always_comb begin
        case (off_y[2:0])
            3'd0: ball_row = 8'h3C;
            3'd1: ball_row = 8'h7E;
            3'd6: ball_row = 8'h7E;
            3'd7: ball_row = 8'h3C;
            default: ball_row = 8'hFF;
        endcase
    end

    assign square_on = (off_x < coord_t'(ball_size)) && (off_y < coord_t'(ball_size));
    assign ball_on = square_on && ball_row[off_x[2:0]];

    // paddle band, inclusive edges
    assign paddle_on = (int'(pix_y) >= paddle_top) && (int'(pix_y) <= paddle_bottom) &&
                       (pix_x >= paddle_left) &&
                       (int'(pix_x) <= int'(paddle_left) + int'(paddle_width) - 1);

    //////////////////////////////////////////////////
    // colour priority
    //////////////////////////////////////////////////

    // bricks on top, then paddle, then ball
    always_comb begin
        if (brick_pix) begin
            graph_rgb = brick_rgb;
        end else if (paddle_on) begin
            graph_rgb = rgb_paddle;
        end else if (ball_on) begin
            graph_rgb = rgb_ball;
        end else begin
            graph_rgb = '0;
        end
    end

    assign graph_on = brick_pix || paddle_on || ball_on;

endmodule

// ==== src/brick_wall.sv ====
`timescale 1ns/10ps

module brick_wall #(
    parameter int BALL_SIZE = breakout_pkg::ball_size,
    parameter int BRICK_W   = breakout_pkg::brick_w,
    parameter int BRICK_H   = breakout_pkg::brick_h
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_tick,
    input  breakout_pkg::ball_pos_t pos,
    input  breakout_pkg::ball_pos_t pos_next,
    input  breakout_pkg::coord_t    pix_x,
    input  breakout_pkg::coord_t    pix_y,
    output breakout_pkg::hit_t      hit_brick,
    output logic                    brick_pix,
    output breakout_pkg::rgb_t      brick_rgb
);
    import breakout_pkg::*;

    // one bit per brick, index row * brick_cols + col
    logic [brick_cnt-1:0] present;
    logic [brick_cnt-1:0] struck;
    hit_t                 brick_flags;

    //////////////////////////////////////////////////
    // collision against the next position
    //////////////////////////////////////////////////

    always_comb begin
        int idx;
        int x0;
        int x1;
        int y0;
        int y1;
        struck = '0;
        brick_flags = '0;
        for (int r = 0; r < brick_rows; r++) begin
            for (int c = 0; c < brick_cols; c++) begin
                idx = r * brick_cols + c;
                x0 = c * BRICK_W;
                x1 = x0 + BRICK_W;
                y0 = r * BRICK_H;
                y1 = y0 + BRICK_H;
                // half-ball overlap on the leading corner
                if (present[idx] &&
                    int'(pos_next.x) + BALL_SIZE / 2 > x0 && int'(pos_next.x) < x1 &&
                    int'(pos_next.y) + BALL_SIZE / 2 > y0 && int'(pos_next.y) < y1) begin
                    struck[idx] = 1'b1;
                    // old position tells which face was crossed
                    if (int'(pos.y) + BALL_SIZE <= y0 || int'(pos.y) >= y1) begin
                        brick_flags.brick_vert = 1'b1;
                    end else if (int'(pos.x) + BALL_SIZE <= x0 || int'(pos.x) >= x1) begin
                        brick_flags.brick_horiz = 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            present <= '1;
            hit_brick <= '0;
        end else if (frame_tick) begin
            present <= present & ~struck;
            hit_brick <= brick_flags;
        end
    end

    //////////////////////////////////////////////////
    // pixel lookup
    //////////////////////////////////////////////////

    // interior only, so the grid lines stay dark
    always_comb begin
        int idx;
        brick_pix = 1'b0;
        brick_rgb = '0;
        for (int r = 0; r < brick_rows; r++) begin
            for (int c = 0; c < brick_cols; c++) begin
                idx = r * brick_cols + c;
                if (present[idx] &&
                    int'(pix_x) > c * BRICK_W && int'(pix_x) < (c + 1) * BRICK_W &&
                    int'(pix_y) > r * BRICK_H && int'(pix_y) < (r + 1) * BRICK_H) begin
                    brick_pix = 1'b1;
                    case (idx % 3)
                        0: brick_rgb = rgb_blue;
                        1: brick_rgb = rgb_red;
                        default: brick_rgb = rgb_green;
                    endcase
                end
            end
        end
    end

endmodule

// ==== src/paddle_ctrl.sv ====
`timescale 1ns/10ps

module paddle_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 frame_tick,
    input  logic [1:0]           btn,
    input  logic [1:0]           sw,
    output breakout_pkg::coord_t left,
    output breakout_pkg::coord_t width
);
    import breakout_pkg::*;

    int right;

    // width select, both upper codes give the narrow bar
    always_comb begin
        case (sw)
            2'b00: width = coord_t'(paddle_w_wide);
            2'b01: width = coord_t'(paddle_w_mid);
            default: width = coord_t'(paddle_w_narrow);
        endcase
    end

    // inclusive right edge
    assign right = int'(left) + int'(width) - 1;

    //////////////////////////////////////////////////
    // paddle position
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // centred for whatever width is selected
            left <= coord_t'(screen_w / 2) - (width >> 1);
        end else if (frame_tick) begin
            // right button has priority
            if (btn[0] && right <= screen_w - paddle_step) begin
                left <= left + coord_t'(paddle_step);
            end else if (btn[1] && int'(left) >= paddle_step) begin
                left <= left - coord_t'(paddle_step);
            end
        end
    end

endmodule

// ==== src/ball_motion.sv ====
`timescale 1ns/10ps

module ball_motion #(
    parameter int BALL_SIZE = breakout_pkg::ball_size
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    frame_tick,
    input  breakout_pkg::dir_t      dir,
    input  breakout_pkg::coord_t    paddle_left,
    input  breakout_pkg::coord_t    paddle_width,
    output breakout_pkg::ball_pos_t pos,
    output breakout_pkg::ball_pos_t pos_next,
    output breakout_pkg::hit_t      hit_wall_paddle
);
    import breakout_pkg::*;

    coord_t step_x;
    coord_t step_y;
    int     paddle_right;
    hit_t   flags;

    // per-axis step, all ones means minus one
    always_comb begin
        step_x = '0;
        step_y = '0;
        case (dir)
            dir_up_left: begin
                step_x = '1;
                step_y = '1;
            end
            dir_up_right: begin
                step_x = coord_t'(1);
                step_y = '1;
            end
            dir_down_right: begin
                step_x = coord_t'(1);
                step_y = coord_t'(1);
            end
            dir_down_left: begin
                step_x = '1;
                step_y = coord_t'(1);
            end
            default: begin
                step_x = '0;
                step_y = '0;
            end
        endcase
    end

    // position only advances on the frame slot
    assign pos_next.x = frame_tick ? pos.x + step_x : pos.x;
    assign pos_next.y = frame_tick ? pos.y + step_y : pos.y;

    //////////////////////////////////////////////////
    // wall and paddle contact
    //////////////////////////////////////////////////

    always_comb begin
        paddle_right = int'(paddle_left) + int'(paddle_width) - 1;
        flags = '0;
        flags.wall_left = (pos_next.x == '0);
        flags.wall_right = (int'(pos_next.x) >= screen_w - BALL_SIZE);
        flags.wall_top = (pos_next.y == '0);
        // only the ball corner is tested against the paddle band
        flags.paddle = (int'(pos_next.y) >= paddle_top) &&
                       (int'(pos_next.y) <= paddle_bottom) &&
                       (pos_next.x >= paddle_left) &&
                       (int'(pos_next.x) <= paddle_right);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // centred, resting on top of the paddle
            pos.x <= coord_t'(screen_w / 2 - BALL_SIZE / 2);
            pos.y <= coord_t'(paddle_top - BALL_SIZE);
            hit_wall_paddle <= '0;
        end else begin
            pos <= pos_next;
            if (frame_tick) begin
                hit_wall_paddle <= flags;
            end
        end
    end

endmodule

// ==== src/ball_dir_fsm.sv ====
`timescale 1ns/10ps

module ball_dir_fsm (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  breakout_pkg::hit_t hit,
    output breakout_pkg::dir_t dir
);
    import breakout_pkg::*;

    logic start_q;
    dir_t dir_nxt;

    // start button sampled into the clock domain
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start;
        end
    end

    //////////////////////////////////////////////////
    // bounce rules
    //////////////////////////////////////////////////

    // vertical reflection wins over horizontal one
    always_comb begin
        dir_nxt = dir;
        case (dir)
            dir_idle: begin
                if (start_q) begin
                    dir_nxt = dir_up_left;
                end
            end
            dir_up_left: begin
                if (hit.valid) begin
                    if (hit.brick_vert || hit.wall_top) begin
                        dir_nxt = dir_down_left;
                    end else if (hit.brick_horiz || hit.wall_left) begin
                        dir_nxt = dir_up_right;
                    end else if (hit.paddle) begin
                        dir_nxt = dir_down_right;
                    end
                end
            end
            dir_up_right: begin
                if (hit.valid) begin
                    if (hit.brick_vert || hit.wall_top) begin
                        dir_nxt = dir_down_right;
                    end else if (hit.brick_horiz || hit.wall_right) begin
                        dir_nxt = dir_up_left;
                    end else if (hit.paddle) begin
                        dir_nxt = dir_down_left;
                    end
                end
            end
            dir_down_right: begin
                // paddle acts like the underside of a brick
                if (hit.valid) begin
                    if (hit.brick_vert || hit.paddle) begin
                        dir_nxt = dir_up_right;
                    end else if (hit.brick_horiz || hit.wall_right) begin
                        dir_nxt = dir_down_left;
                    end
                end
            end
            dir_down_left: begin
                if (hit.valid) begin
                    if (hit.brick_vert || hit.paddle) begin
                        dir_nxt = dir_up_left;
                    end else if (hit.brick_horiz || hit.wall_left) begin
                        dir_nxt = dir_down_right;
                    end
                end
            end
            default: begin
                dir_nxt = dir_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            dir <= dir_idle;
        end else begin
            dir <= dir_nxt;
        end
    end

endmodule

// ==== src/breakout_pkg.sv ====
package breakout_pkg;

    //////////////////////////////////////////////////
    // screen geometry
    //////////////////////////////////////////////////

    // raster coordinate, one word per axis
    typedef logic [9:0] coord_t;

    localparam int screen_w = 640;
    localparam int screen_h = 480;
    // update slot sits in vertical blanking, column 0
    localparam int frame_tick_y = screen_h + 1;

    // brick grid
    localparam int brick_w = 40;
    localparam int brick_h = 30;
    localparam int brick_cols = 16;
    localparam int brick_rows = 6;
    localparam int brick_cnt = brick_cols * brick_rows;

    // square ball box, round mask inside
    localparam int ball_size = 8;

    // paddle band and speed
    localparam int paddle_top = 453;
    localparam int paddle_bottom = 457;
    localparam int paddle_step = 2;
    localparam int paddle_w_wide = 600;
    localparam int paddle_w_mid = 40;
    localparam int paddle_w_narrow = 30;

    //////////////////////////////////////////////////
    // colours and shared types
    //////////////////////////////////////////////////

    typedef logic [2:0] rgb_t;

    localparam rgb_t rgb_blue = 3'b001;
    localparam rgb_t rgb_red = 3'b100;
    localparam rgb_t rgb_green = 3'b010;
    localparam rgb_t rgb_paddle = 3'b110;
    localparam rgb_t rgb_ball = 3'b111;

    // ball heading, diagonals only
    typedef enum logic [2:0] {
        dir_idle       = 3'd0,
        dir_up_left    = 3'd1,
        dir_up_right   = 3'd2,
        dir_down_right = 3'd3,
        dir_down_left  = 3'd4
    } dir_t;

    // upper-left corner of the ball box
    typedef struct packed {
        coord_t x;
        coord_t y;
    } ball_pos_t;

    // collision flags, valid in the cycle after the tick
    typedef struct packed {
        logic valid;
        logic brick_vert;
        logic brick_horiz;
        logic wall_left;
        logic wall_right;
        logic wall_top;
        logic paddle;
    } hit_t;

endpackage
